// ==== Makefile ====
# Verilator simulation of the VGA test-pattern source

SIM := obj_dir/Vtb_vga_top

.PHONY: all run clean

all: run

# rebuilt only when the file list or a listed source changes
$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert -j 0 --top-module tb_vga_top -f verilog.f

# status comes from the search for the pass line
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep "Simulation passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== hw/pattern_gen.sv ====
`timescale 1ns/1ps

module pattern_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vga_pkg::vga_timing_t timing,
    input  vga_pkg::pattern_t    pattern,
    input  logic                 video_on,
    output logic                 hsync,
    output logic                 vsync,
    output vga_pkg::colour_t     rgb
);

    import vga_pkg::*;

    // pixel is inside the window and video is running
    logic pixel_active;

    // which of the eight bars, x / bar_width
    logic [2:0] bar_idx;
    coord_t     bar_quot;

    // per-pattern colours
    colour_t bars_colour;
    colour_t grid_colour;
    colour_t grad_colour;
    colour_t check_colour;

    // colour before the output register
    colour_t colour_next;

    assign pixel_active = timing.display_en && video_on;

    // constant divide, only three bits survive inside the window
    assign bar_quot = timing.x / coord_t'(bar_width);
    assign bar_idx  = bar_quot[2:0];

    // bars
    // index bits pick red, green and blue
    assign bars_colour = {
        {4{bar_idx[2]}},
        {4{bar_idx[1]}},
        {4{bar_idx[0]}}
    };

    // grid lines every 32 pixels in both directions
    assign grid_colour = ((timing.x[4:0] == 5'd0) || (timing.y[4:0] == 5'd0)) ?
                         colour_white : colour_black;

    // red ramps along x, green along y
    assign grad_colour = {timing.x[9:6], timing.y[8:5], 4'h0};

    // 32 pixel squares
    assign check_colour = (timing.x[5] ^ timing.y[5]) ? colour_white : colour_black;

    // pattern select with blanking
    always_comb begin
        colour_next = colour_black;
        if (pixel_active) begin
            case (pattern)
                pat_bars:     colour_next = bars_colour;
                pat_grid:     colour_next = grid_colour;
                pat_gradient: colour_next = grad_colour;
                pat_checker:  colour_next = check_colour;
                default:      colour_next = colour_black;
            endcase
        end
    end

    // output register
    // syncs ride along so they stay aligned with the colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            rgb   <= colour_black;
        end else begin
            hsync <= timing.hsync;
            vsync <= timing.vsync;
            rgb   <= colour_next;
        end
    end

    // no colour may leak into the borders or retrace
    a_blank_outside : assert property (
        @(posedge clk) disable iff (!rst_n)
        !timing.display_en |=> (rgb == colour_black)
    );

endmodule

// ==== hw/pattern_sequencer.sv ====
`timescale 1ns/1ps

module pattern_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              frame_start,
    input  logic              video_enable,
    output vga_pkg::pattern_t pattern,
    output logic              video_on
);

    import vga_pkg::*;

    seq_state_t state;
    frame_cnt_t frame_cnt;

    // count reached the last frame of the current pattern
    logic pattern_done;

    assign pattern_done = (frame_cnt == frame_cnt_t'(frames_per_pattern - 1));

    // step to the following pattern, checker wraps back to bars
    function automatic pattern_t next_pattern(input pattern_t cur);
        pattern_t nxt;
        case (cur)
            pat_bars:     nxt = pat_grid;
            pat_grid:     nxt = pat_gradient;
            pat_gradient: nxt = pat_checker;
            pat_checker:  nxt = pat_bars;
            default:      nxt = pat_bars;
        endcase
        return nxt;
    endfunction

    // sequencer FSM
    // everything is evaluated only on frame_start, so changes land in vsync retrace
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            pattern   <= pat_bars;
            frame_cnt <= '0;
        end else if (frame_start) begin
            case (state)
                st_idle: begin
                    // always restart with bars at the first frame
                    if (video_enable) begin
                        state     <= st_run;
                        pattern   <= pat_bars;
                        frame_cnt <= '0;
                    end
                end
                st_run: begin
                    if (!video_enable) begin
                        // drop out for at least this whole frame
                        state <= st_idle;
                    end else if (pattern_done) begin
                        pattern   <= next_pattern(pattern);
                        frame_cnt <= '0;
                    end else begin
                        frame_cnt <= frame_cnt + frame_cnt_t'(1);
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // straight decode of the state register
    assign video_on = (state == st_run);

    // pattern and gating only move right after a frame start
    a_change_at_frame : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((pattern != $past(pattern)) || (video_on != $past(video_on)))
            |-> $past(frame_start)
    );

endmodule

// ==== hw/vga_pkg.sv ====
package vga_pkg;

    // horizontal timing in pixel clocks
    // retrace first, then front border, visible area, back border
    localparam int h_display = 640;
    localparam int h_front   = 48;
    localparam int h_back    = 16;
    localparam int h_retrace = 96;
    localparam int h_total   = 800;

    // vertical timing in lines, same ordering as horizontal
    localparam int v_display = 480;
    localparam int v_front   = 33;
    localparam int v_back    = 10;
    localparam int v_retrace = 2;
    localparam int v_total   = 525;

    // visible window bounds in raw scan counts, end is exclusive
    localparam int h_start = h_retrace + h_front;
    localparam int h_end   = h_start + h_display;
    localparam int v_start = v_retrace + v_front;
    localparam int v_end   = v_start + v_display;

    // frames each pattern stays on screen
    localparam int frames_per_pattern = 2;

    // eight colour bars across the visible width
    localparam int bar_width = h_display / 8;

    // scan count or pixel coordinate
    typedef logic [9:0] coord_t;
    // 4 bits per channel, red on top, blue at the bottom
    typedef logic [11:0] colour_t;
    // frame count within one pattern
    typedef logic [0:0] frame_cnt_t;

    localparam colour_t colour_black = 12'h000;
    localparam colour_t colour_white = 12'hfff;

    // scan state for one pixel, x and y relative to the visible origin
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   display_en;
        coord_t x;
        coord_t y;
    } vga_timing_t;

    // order matters, the sequencer steps through these in turn
    typedef enum logic [1:0] {
        pat_bars,
        pat_grid,
        pat_gradient,
        pat_checker
    } pattern_t;

    typedef enum logic {
        st_idle,
        st_run
    } seq_state_t;

endpackage

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing (
    input  logic                 clk,
    input  logic                 rst_n,
    output vga_pkg::vga_timing_t timing,
    output logic                 frame_start
);

    import vga_pkg::*;

    // raw scan position, zero is the start of sync retrace
    coord_t h_cnt;
    coord_t v_cnt;

    // last count of a line and of a frame
    logic h_last;
    logic v_last;

    // decoded window flags
    logic h_visible;
    logic v_visible;

    assign h_last = (h_cnt == coord_t'(h_total - 1));
    assign v_last = (v_cnt == coord_t'(v_total - 1));

    // horizontal counter
    // one pixel per clock, wraps at the line total
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + coord_t'(1);
        end
    end

    // vertical counter
    // steps once per line, on the horizontal wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_cnt <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + coord_t'(1);
            end
        end
    end

    // visible window, start inclusive, end exclusive
    assign h_visible = (h_cnt >= coord_t'(h_start)) && (h_cnt < coord_t'(h_end));
    assign v_visible = (v_cnt >= coord_t'(v_start)) && (v_cnt < coord_t'(v_end));

    // decode the scan state
    always_comb begin
        // syncs are active low during retrace at the head of line and frame
        timing.hsync      = (h_cnt >= coord_t'(h_retrace));
        timing.vsync      = (v_cnt >= coord_t'(v_retrace));
        timing.display_en = h_visible && v_visible;
        // relative coords, meaningless outside the window
        timing.x          = h_cnt - coord_t'(h_start);
        timing.y          = v_cnt - coord_t'(v_start);
    end

    // single cycle at the very top of each frame
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    // counters must never run past the frame totals
    a_h_cnt_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        h_cnt < coord_t'(h_total)
    );

    a_v_cnt_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        v_cnt < coord_t'(v_total)
    );

endmodule

// ==== hw/vga_top.sv ====
`timescale 1ns/1ps

module vga_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             video_enable,
    output logic             hsync,
    output logic             vsync,
    output vga_pkg::colour_t rgb
);

    import vga_pkg::*;

    // scan state, combinational from the counters
    vga_timing_t timing;
    // one cycle at count zero of each frame
    logic        frame_start;

    // sequencer outputs, stable for whole frames
    pattern_t    pattern;
    logic        video_on;

    // scan counters and sync decode
    vga_timing vga_timing_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .timing      (timing),
        .frame_start (frame_start)
    );

    // picks the pattern and gates video per frame
    pattern_sequencer pattern_sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_start  (frame_start),
        .video_enable (video_enable),
        .pattern      (pattern),
        .video_on     (video_on)
    );

    // colour plus output register
    // all three outputs lag the scan by one cycle
    pattern_gen pattern_gen_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .timing   (timing),
        .pattern  (pattern),
        .video_on (video_on),
        .hsync    (hsync),
        .vsync    (vsync),
        .rgb      (rgb)
    );

endmodule

// ==== tb/tb_vga_top.sv ====
`timescale 1ns/1ps

module tb_vga_top;

    import vga_pkg::*;

    // what the DUT should drive in one cycle
    typedef struct packed {
        logic    hsync;
        logic    vsync;
        colour_t rgb;
    } vga_out_t;

    localparam int clk_period_ns = 20;
    localparam int frame_cycles  = h_total * v_total;
    // frames after reset release before the run ends
    localparam int last_frame    = 12;
    localparam int watchdog_ns   = 13 * frame_cycles * clk_period_ns;

    logic    clk;
    logic    rst_n;
    logic    video_enable;
    logic    hsync;
    logic    vsync;
    colour_t rgb;

    // reference model of scan and sequencer
    int       m_h;
    int       m_v;
    logic     m_running;
    pattern_t m_pattern;
    int       m_frame_cnt;

    // expectation for the cycle just gone, outputs lag by one
    vga_out_t exp_prev;
    int       prev_h;
    int       prev_v;
    vga_out_t dut_out;

    // cycle 0 is the first cycle after reset release
    int stim_cycle;

    vga_top vga_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .video_enable (video_enable),
        .hsync        (hsync),
        .vsync        (vsync),
        .rgb          (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    // expected syncs and colour for a raw scan position
    function automatic vga_out_t expected_out(
        input int       h,
        input int       v,
        input pattern_t pat,
        input logic     on
    );
        vga_out_t   r;
        int         x;
        int         y;
        logic [2:0] bar;
        r.hsync = (h >= h_retrace);
        r.vsync = (v >= v_retrace);
        r.rgb   = 12'h000;
        x = h - h_start;
        y = v - v_start;
        if (on && (x >= 0) && (x < h_display) && (y >= 0) && (y < v_display)) begin
            case (pat)
                pat_bars: begin
                    // eight bars of 80 pixels
                    bar   = 3'(x / 80);
                    r.rgb = {{4{bar[2]}}, {4{bar[1]}}, {4{bar[0]}}};
                end
                pat_grid: begin
                    if ((x % 32 == 0) || (y % 32 == 0)) begin
                        r.rgb = 12'hfff;
                    end
                end
                pat_gradient: begin
                    // x bits 9..6 and y bits 8..5
                    r.rgb = {4'(x / 64), 4'(y / 32), 4'h0};
                end
                default: begin
                    if (((x / 32) % 2) != ((y / 32) % 2)) begin
                        r.rgb = 12'hfff;
                    end
                end
            endcase
        end
        return r;
    endfunction

    // sequencer rules, applied at each modelled frame start
    task automatic model_frame_start(input logic en);
        if (!m_running) begin
            if (en) begin
                m_running   = 1'b1;
                m_pattern   = pat_bars;
                m_frame_cnt = 0;
            end
        end else if (!en) begin
            m_running = 1'b0;
        end else begin
            m_frame_cnt = m_frame_cnt + 1;
            if (m_frame_cnt == frames_per_pattern) begin
                // enum order, checker back to bars
                m_pattern   = pattern_t'((int'(m_pattern) + 1) % 4);
                m_frame_cnt = 0;
            end
        end
    endtask

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    // step the stimulus to the start of a given cycle
    task automatic wait_until(input int target);
        while (stim_cycle < target) begin
            @(posedge clk);
            stim_cycle++;
        end
    endtask

    // random spot inside a frame, clear of its first and last line
    function automatic int point_in_frame(input int frame);
        int line;
        int pixel;
        line  = 1 + int'($urandom % (v_total - 2));
        pixel = int'($urandom % h_total);
        return frame * frame_cycles + line * h_total + pixel;
    endfunction

    // model and compare at the falling edge, where everything is settled
    always @(negedge clk) begin
        if (rst_n) begin
            dut_out = {hsync, vsync, rgb};
            assert ({dut_out.hsync, dut_out.vsync} == {exp_prev.hsync, exp_prev.vsync})
            else begin
                $display("error at time %0t: hsync %b vsync %b, expected %b %b at h %0d v %0d",
                         $time, dut_out.hsync, dut_out.vsync, exp_prev.hsync,
                         exp_prev.vsync, prev_h, prev_v);
                report_failure();
            end
            assert (dut_out.rgb == exp_prev.rgb) else begin
                $display("error at time %0t: rgb %03h, expected %03h at h %0d v %0d pattern %s",
                         $time, dut_out.rgb, exp_prev.rgb, prev_h, prev_v, m_pattern.name());
                report_failure();
            end
            exp_prev = expected_out(m_h, m_v, m_pattern, m_running);
            prev_h   = m_h;
            prev_v   = m_v;
            // DUT samples the enable at the end of this cycle
            if ((m_h == 0) && (m_v == 0)) begin
                model_frame_start(video_enable);
            end
            if (m_h == h_total - 1) begin
                m_h = 0;
                m_v = (m_v == v_total - 1) ? 0 : m_v + 1;
            end else begin
                m_h = m_h + 1;
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        video_enable = 1'b0;
        m_h          = 0;
        m_v          = 0;
        m_running    = 1'b0;
        m_pattern    = pat_bars;
        m_frame_cnt  = 0;
        // reset values of the output register
        exp_prev     = '0;
        prev_h       = 0;
        prev_v       = 0;
        stim_cycle   = 0;
        void'($urandom(79363));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // frame 0 stays dark, enable rises somewhere inside it
        wait_until(point_in_frame(0));
        video_enable <= 1'b1;
        // frames 1 to 9 run, frame 10 sees the enable low
        wait_until(point_in_frame(9));
        video_enable <= 1'b0;
        wait_until(point_in_frame(10));
        video_enable <= 1'b1;
        // past the last delayed output of frame 11
        wait_until(last_frame * frame_cycles + 2);
        $display("Simulation passed");
        $finish;
    end

    // guards against a stuck run
    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within 13 frame times");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog.f ====
hw/vga_pkg.sv
hw/vga_timing.sv
hw/pattern_sequencer.sv
hw/pattern_gen.sv
hw/vga_top.sv
tb/tb_vga_top.sv
